// File: project.f
+incdir+.
xdma_pkg.sv
xdma_burst_writer.sv
xdma_grant_gate.sv
xdma_window_demux.sv
xdma_adapter_top.sv
tb_xdma_adapter.sv

// File: run_sim.sh
#!/bin/sh
# Build with Verilator, run, then judge the run from its log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal --top-module tb_xdma_adapter -f project.f -o tb_sim \
  > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/tb_sim | tee sim.log
grep -qF '*** PASSED ***' sim.log && echo "Simulation passed" || { echo "Simulation failed"; exit 1; }

// File: tb_xdma_adapter.sv
`timescale 1ns/10ps

`include "xdma_config.svh"

module tb_xdma_adapter;

  localparam int Limit = 100;

  // ------------------------------
  // DUT signals
  // ------------------------------
  logic                   clk_i;
  logic                   rst_ni;
  xdma_pkg::addr_t        cluster_base_i;
  xdma_pkg::narrow_data_t to_remote_cfg_i;
  xdma_pkg::xfer_desc_t   to_remote_cfg_desc_i;
  logic                   to_remote_cfg_valid_i;
  logic                   to_remote_cfg_ready_o;
  xdma_pkg::wide_data_t   to_remote_data_i;
  xdma_pkg::xfer_desc_t   to_remote_data_desc_i;
  logic                   to_remote_data_valid_i;
  logic                   to_remote_data_ready_o;
  xdma_pkg::narrow_beat_t narrow_out_o;
  logic                   narrow_out_valid_o;
  logic                   narrow_out_ready_i;
  xdma_pkg::wide_beat_t   wide_out_o;
  logic                   wide_out_valid_o;
  logic                   wide_out_ready_i;
  xdma_pkg::narrow_beat_t narrow_in_i;
  logic                   narrow_in_valid_i;
  logic                   narrow_in_ready_o;
  xdma_pkg::wide_beat_t   wide_in_i;
  logic                   wide_in_valid_i;
  logic                   wide_in_ready_o;
  xdma_pkg::narrow_data_t from_remote_cfg_o;
  logic                   from_remote_cfg_valid_o;
  logic                   from_remote_cfg_ready_i;
  xdma_pkg::narrow_data_t from_remote_finish_o;
  logic                   from_remote_finish_valid_o;
  logic                   from_remote_finish_ready_i;
  xdma_pkg::wide_data_t   from_remote_data_o;
  logic                   from_remote_data_valid_o;
  logic                   from_remote_data_ready_i;

  // Stimulus words and captured transfers
  xdma_pkg::narrow_data_t cfg_words [8];
  xdma_pkg::wide_data_t   data_words [4];
  xdma_pkg::narrow_beat_t narrow_q [$];
  xdma_pkg::wide_beat_t   wide_q [$];
  xdma_pkg::narrow_data_t cfg_q [$];
  xdma_pkg::narrow_data_t finish_q [$];
  xdma_pkg::wide_data_t   rx_data_q [$];
  logic [31:0]            rng_state;
  int                     errors;

  xdma_adapter_top UUT (.*);

  always #5 clk_i = ~clk_i;

  // Falling edge sees settled handshakes of the next rising edge
  always @(negedge clk_i) begin
    if (narrow_out_valid_o && narrow_out_ready_i) narrow_q.push_back(narrow_out_o);
    if (wide_out_valid_o && wide_out_ready_i) wide_q.push_back(wide_out_o);
    if (from_remote_cfg_valid_o && from_remote_cfg_ready_i) cfg_q.push_back(from_remote_cfg_o);
    if (from_remote_finish_valid_o && from_remote_finish_ready_i) begin
      finish_q.push_back(from_remote_finish_o);
    end
    if (from_remote_data_valid_o && from_remote_data_ready_i) begin
      rx_data_q.push_back(from_remote_data_o);
    end
  end

  // ------------------------------
  // Helpers
  // ------------------------------
  function automatic logic [31:0] next_rand();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  function automatic xdma_pkg::narrow_data_t rand_narrow();
    return {next_rand(), next_rand()};
  endfunction

  function automatic xdma_pkg::wide_data_t rand_wide();
    xdma_pkg::wide_data_t w;
    for (int k = 0; k < 16; k++) begin
      w[32*k +: 32] = next_rand();
    end
    return w;
  endfunction

  // Reference window rule
  // Index counts down from the region top
  function automatic xdma_pkg::addr_t expected_base(xdma_pkg::addr_t peer, int idx);
    xdma_pkg::addr_t top;
    if (peer[39:0] >= 40'h00_8000_0000) begin
      // Main memory ends at 4 GiB above the chip id
      top = {peer[47:40], 40'h0} + 48'h1_0000_0000;
    end else begin
      top = {peer[47:20], 20'h0} + `XDMA_CLUSTER_SPACE;
    end
    return top - 48'(idx + 1) * 48'(`XDMA_WINDOW_BYTES);
  endfunction

  function automatic logic port_ready(int port);
    case (port)
      0:       return to_remote_cfg_ready_o;
      1:       return to_remote_data_ready_o;
      2:       return narrow_in_ready_o;
      default: return wide_in_ready_o;
    endcase
  endfunction

  function automatic int queue_size(int which);
    case (which)
      0:       return narrow_q.size();
      1:       return wide_q.size();
      2:       return cfg_q.size();
      3:       return finish_q.size();
      default: return rx_data_q.size();
    endcase
  endfunction

  task automatic mismatch(input string name, input logic [511:0] got, input logic [511:0] exp);
    errors++;
    $display("Error: %s got %0h expected %0h", name, got, exp);
  endtask

  // Ready sampled at falling edges
  // Returns just after the transfer edge
  task automatic wait_accept(input int port, input string what);
    int t;
    t = 0;
    @(negedge clk_i);
    while (!port_ready(port) && t < Limit) begin
      @(negedge clk_i);
      t++;
    end
    if (!port_ready(port)) begin
      errors++;
      $display("Timeout: %s was never accepted", what);
    end
    @(posedge clk_i);
    #1;
  endtask

  task automatic wait_count(input int which, input int n, input string what);
    int t;
    t = 0;
    while (queue_size(which) < n && t < Limit) begin
      @(posedge clk_i);
      #1;
      t++;
    end
    if (queue_size(which) < n) begin
      errors++;
      $display("Timeout: %s, only %0d of %0d arrived", what, queue_size(which), n);
    end
  endtask

  task automatic send_cfg(input xdma_pkg::addr_t peer, input int n);
    to_remote_cfg_desc_i.peer_addr = peer;
    to_remote_cfg_desc_i.beats     = 16'(n);
    for (int i = 0; i < n; i++) begin
      to_remote_cfg_i       = cfg_words[i];
      to_remote_cfg_valid_i = 1'b1;
      wait_accept(0, "control word");
    end
    to_remote_cfg_valid_i = 1'b0;
  endtask

  task automatic send_data(input xdma_pkg::addr_t peer, input int n);
    to_remote_data_desc_i.peer_addr = peer;
    to_remote_data_desc_i.beats     = 16'(n);
    for (int i = 0; i < n; i++) begin
      to_remote_data_i       = data_words[i];
      to_remote_data_valid_i = 1'b1;
      wait_accept(1, "data word");
    end
    to_remote_data_valid_i = 1'b0;
  endtask

  task automatic write_narrow_in(input xdma_pkg::addr_t addr, input xdma_pkg::narrow_data_t d);
    narrow_in_i.addr  = addr;
    narrow_in_i.data  = d;
    narrow_in_i.last  = 1'b1;
    narrow_in_valid_i = 1'b1;
    wait_accept(2, "narrow inbound write");
    narrow_in_valid_i = 1'b0;
  endtask

  // Narrow beats step by 8 bytes from the window base
  task automatic check_narrow(input xdma_pkg::addr_t base, input int n);
    xdma_pkg::narrow_beat_t b;
    for (int i = 0; i < n && narrow_q.size() != 0; i++) begin
      b = narrow_q.pop_front();
      if (b.addr !== base + 48'(8 * i)) begin
        mismatch("narrow_out.addr", 512'(b.addr), 512'(base + 48'(8 * i)));
      end
      if (b.data !== cfg_words[i]) mismatch("narrow_out.data", 512'(b.data), 512'(cfg_words[i]));
      if (b.last !== (i == n - 1)) mismatch("narrow_out.last", 512'(b.last), 512'(i == n - 1));
    end
    if (narrow_q.size() != 0) begin
      errors++;
      $display("Extra beats on narrow_out after the burst");
    end
  endtask

  // Wide beats step by 64 bytes
  task automatic check_wide(input xdma_pkg::addr_t base, input int n);
    xdma_pkg::wide_beat_t b;
    for (int i = 0; i < n && wide_q.size() != 0; i++) begin
      b = wide_q.pop_front();
      if (b.addr !== base + 48'(64 * i)) begin
        mismatch("wide_out.addr", 512'(b.addr), 512'(base + 48'(64 * i)));
      end
      if (b.data !== data_words[i]) mismatch("wide_out.data", b.data, data_words[i]);
      if (b.last !== (i == n - 1)) mismatch("wide_out.last", 512'(b.last), 512'(i == n - 1));
    end
    if (wide_q.size() != 0) begin
      errors++;
      $display("Extra beats on wide_out after the burst");
    end
  endtask

  task automatic watch_idle(input int cycles, input string what);
    repeat (cycles) begin
      @(negedge clk_i);
      if (wide_out_valid_o) begin
        errors++;
        $display("Data burst left %s", what);
      end
    end
    @(posedge clk_i);
    #1;
  endtask

  // ------------------------------
  // Tests
  // ------------------------------
  task automatic test_cfg_burst(input xdma_pkg::addr_t peer, input int n, input string what);
    for (int i = 0; i < n; i++) begin
      cfg_words[i] = rand_narrow();
    end
    narrow_q.delete();
    send_cfg(peer, n);
    wait_count(0, n, what);
    check_narrow(expected_base(peer, 1), n);
  endtask

  task automatic test_grant_gating();
    xdma_pkg::addr_t peer;
    xdma_pkg::addr_t grant_addr;
    peer       = 48'h0000_0070_0040;
    grant_addr = expected_base(cluster_base_i, 2) + 48'h10;
    wide_q.delete();
    // Each of two bursts waits for its own grant
    repeat (2) begin
      for (int i = 0; i < 3; i++) begin
        data_words[i] = rand_wide();
      end
      fork
        send_data(peer, 3);
        begin
          watch_idle(20, "without a grant");
          write_narrow_in(grant_addr, rand_narrow());
        end
      join
      wait_count(1, 3, "granted data beats");
      check_wide(expected_base(peer, 0), 3);
    end
  endtask

  task automatic test_receive_routing();
    xdma_pkg::narrow_data_t w_cfg;
    xdma_pkg::narrow_data_t w_fin;
    xdma_pkg::wide_data_t   w_data;
    cfg_q.delete();
    finish_q.delete();
    rx_data_q.delete();
    w_cfg  = rand_narrow();
    w_fin  = rand_narrow();
    w_data = rand_wide();
    write_narrow_in(expected_base(cluster_base_i, 1) + 48'h18, w_cfg);
    write_narrow_in(expected_base(cluster_base_i, 3) + 48'h20, w_fin);
    wait_count(2, 1, "configuration word");
    wait_count(3, 1, "finish word");
    if (cfg_q.size() != 0 && cfg_q[0] !== w_cfg) begin
      mismatch("from_remote_cfg", 512'(cfg_q[0]), 512'(w_cfg));
    end
    if (finish_q.size() != 0 && finish_q[0] !== w_fin) begin
      mismatch("from_remote_finish", 512'(finish_q[0]), 512'(w_fin));
    end
    cfg_q.delete();
    finish_q.delete();
    // Stray write far below every window
    write_narrow_in(cluster_base_i + 48'h40, rand_narrow());
    repeat (3) @(posedge clk_i);
    #1;
    if (cfg_q.size() + finish_q.size() != 0) begin
      errors++;
      $display("Write outside all windows reached a receive output");
    end
    wide_in_i.addr  = 48'h0;
    wide_in_i.data  = w_data;
    wide_in_i.last  = 1'b1;
    wide_in_valid_i = 1'b1;
    wait_accept(3, "wide inbound write");
    wide_in_valid_i = 1'b0;
    wait_count(4, 1, "received data word");
    if (rx_data_q.size() != 0 && rx_data_q[0] !== w_data) begin
      mismatch("from_remote_data", rx_data_q[0], w_data);
    end
  endtask

  task automatic test_back_pressure();
    xdma_pkg::addr_t        peer;
    xdma_pkg::narrow_beat_t held;
    int                     t;
    peer = 48'h0000_00A0_0000;
    for (int i = 0; i < 5; i++) begin
      cfg_words[i] = rand_narrow();
    end
    narrow_q.delete();
    narrow_out_ready_i = 1'b0;
    fork
      send_cfg(peer, 5);
      begin
        t = 0;
        @(negedge clk_i);
        while (!narrow_out_valid_o && t < Limit) begin
          @(negedge clk_i);
          t++;
        end
        if (!narrow_out_valid_o) begin
          errors++;
          $display("Timeout: no beat appeared on narrow_out");
        end
        held = narrow_out_o;
        // Stalled beat must not move
        repeat (6) begin
          @(negedge clk_i);
          if (narrow_out_o !== held) mismatch("narrow_out held", 512'(narrow_out_o), 512'(held));
          if (!narrow_out_valid_o) begin
            errors++;
            $display("Valid on narrow_out dropped under back-pressure");
          end
        end
        @(posedge clk_i);
        #1;
        narrow_out_ready_i = 1'b1;
      end
    join
    wait_count(0, 5, "beats after back-pressure");
    check_narrow(expected_base(peer, 1), 5);
  endtask

  initial begin
    clk_i                      = 1'b0;
    rst_ni                     = 1'b0;
    rng_state                  = 32'd77842;
    errors                     = 0;
    cluster_base_i             = 48'h0000_0020_0000;
    to_remote_cfg_i            = '0;
    to_remote_cfg_desc_i       = '0;
    to_remote_cfg_valid_i      = 1'b0;
    to_remote_data_i           = '0;
    to_remote_data_desc_i      = '0;
    to_remote_data_valid_i     = 1'b0;
    narrow_out_ready_i         = 1'b1;
    wide_out_ready_i           = 1'b1;
    narrow_in_i                = '0;
    narrow_in_valid_i          = 1'b0;
    wide_in_i                  = '0;
    wide_in_valid_i            = 1'b0;
    from_remote_cfg_ready_i    = 1'b1;
    from_remote_finish_ready_i = 1'b1;
    from_remote_data_ready_i   = 1'b1;
    repeat (4) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;

    test_cfg_burst(48'h0000_0051_2340, 4, "cluster peer beats");
    test_cfg_burst(48'h0300_9000_1000, 3, "main memory peer beats");
    test_grant_gating();
    test_receive_routing();
    test_back_pressure();

    $display("Tests run: 5, errors: %0d", errors);
    if (errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

// File: xdma_adapter_top.sv
`timescale 1ns/10ps

module xdma_adapter_top (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  xdma_pkg::addr_t        cluster_base_i,
  // Control words to the peer
  input  xdma_pkg::narrow_data_t to_remote_cfg_i,
  input  xdma_pkg::xfer_desc_t   to_remote_cfg_desc_i,
  input  logic                   to_remote_cfg_valid_i,
  output logic                   to_remote_cfg_ready_o,
  // Data words to the peer
  input  xdma_pkg::wide_data_t   to_remote_data_i,
  input  xdma_pkg::xfer_desc_t   to_remote_data_desc_i,
  input  logic                   to_remote_data_valid_i,
  output logic                   to_remote_data_ready_o,
  // Outbound narrow channel
  output xdma_pkg::narrow_beat_t narrow_out_o,
  output logic                   narrow_out_valid_o,
  input  logic                   narrow_out_ready_i,
  // Outbound wide channel
  output xdma_pkg::wide_beat_t   wide_out_o,
  output logic                   wide_out_valid_o,
  input  logic                   wide_out_ready_i,
  // Inbound narrow channel
  input  xdma_pkg::narrow_beat_t narrow_in_i,
  input  logic                   narrow_in_valid_i,
  output logic                   narrow_in_ready_o,
  // Inbound wide channel
  input  xdma_pkg::wide_beat_t   wide_in_i,
  input  logic                   wide_in_valid_i,
  output logic                   wide_in_ready_o,
  // Received streams
  output xdma_pkg::narrow_data_t from_remote_cfg_o,
  output logic                   from_remote_cfg_valid_o,
  input  logic                   from_remote_cfg_ready_i,
  output xdma_pkg::narrow_data_t from_remote_finish_o,
  output logic                   from_remote_finish_valid_o,
  input  logic                   from_remote_finish_ready_i,
  output xdma_pkg::wide_data_t   from_remote_data_o,
  output logic                   from_remote_data_valid_o,
  input  logic                   from_remote_data_ready_i
);

  // ------------------------------
  // Send side
  // ------------------------------
  // Control words, never gated
  xdma_burst_writer #(
    .data_t (xdma_pkg::narrow_data_t),
    .beat_t (xdma_pkg::narrow_beat_t),
    .Window (xdma_pkg::CfgWin)
  ) cfg_writer (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .data_i      (to_remote_cfg_i),
    .valid_i     (to_remote_cfg_valid_i),
    .ready_o     (to_remote_cfg_ready_o),
    .desc_i      (to_remote_cfg_desc_i),
    .first_o     (),
    .out_o       (narrow_out_o),
    .out_valid_o (narrow_out_valid_o),
    .out_ready_i (narrow_out_ready_i)
  );

  // Gated handshake into the data writer
  logic data_gated_valid;
  logic data_writer_ready;
  logic data_first;
  // Grant credits from the receive side
  logic grant_valid;
  logic grant_ready;

  xdma_burst_writer #(
    .data_t (xdma_pkg::wide_data_t),
    .beat_t (xdma_pkg::wide_beat_t),
    .Window (xdma_pkg::DataWin)
  ) data_writer (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .data_i      (to_remote_data_i),
    .valid_i     (data_gated_valid),
    .ready_o     (data_writer_ready),
    .desc_i      (to_remote_data_desc_i),
    .first_o     (data_first),
    .out_o       (wide_out_o),
    .out_valid_o (wide_out_valid_o),
    .out_ready_i (wide_out_ready_i)
  );

  // A data burst opens only against a held grant
  xdma_grant_gate i_grant_gate (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .data_valid_i   (to_remote_data_valid_i),
    .first_i        (data_first),
    .writer_ready_i (data_writer_ready),
    .data_valid_o   (data_gated_valid),
    .data_ready_o   (to_remote_data_ready_o),
    .grant_valid_i  (grant_valid),
    .grant_ready_o  (grant_ready)
  );

  // ------------------------------
  // Receive side
  // ------------------------------
  xdma_window_demux i_window_demux (
    .cluster_base_i (cluster_base_i),
    .in_i           (narrow_in_i),
    .in_valid_i     (narrow_in_valid_i),
    .in_ready_o     (narrow_in_ready_o),
    .cfg_o          (from_remote_cfg_o),
    .cfg_valid_o    (from_remote_cfg_valid_o),
    .cfg_ready_i    (from_remote_cfg_ready_i),
    .grant_valid_o  (grant_valid),
    .grant_ready_i  (grant_ready),
    .finish_o       (from_remote_finish_o),
    .finish_valid_o (from_remote_finish_valid_o),
    .finish_ready_i (from_remote_finish_ready_i)
  );

  // Wide writes are always data, no decode
  assign from_remote_data_o       = wide_in_i.data;
  assign from_remote_data_valid_o = wide_in_valid_i;
  assign wide_in_ready_o          = from_remote_data_ready_i;

endmodule

// File: xdma_burst_writer.sv
`timescale 1ns/10ps

module xdma_burst_writer #(
  parameter type data_t = xdma_pkg::narrow_data_t,
  parameter type beat_t = xdma_pkg::narrow_beat_t,
  // Target window on the peer, a xdma_pkg::window_e value
  parameter int  Window = 0
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  // Payload stream in
  input  data_t                data_i,
  input  logic                 valid_i,
  output logic                 ready_o,
  input  xdma_pkg::xfer_desc_t desc_i,
  // High while the next accepted word opens a burst
  output logic                 first_o,
  // Addressed beats out
  output beat_t                out_o,
  output logic                 out_valid_o,
  input  logic                 out_ready_i
);

  localparam xdma_pkg::addr_t BeatBytes =
    xdma_pkg::addr_t'(xdma_pkg::beat_bytes($bits(data_t)));

  // ------------------------------
  // State
  // ------------------------------
  logic            first_q;
  xdma_pkg::len_t  beat_cnt_q;
  // Beats still to come after the current one
  xdma_pkg::len_t  remain_q;
  xdma_pkg::addr_t base_q;
  beat_t           out_q;
  logic            out_valid_q;

  // Next beat, before registering
  logic            accept;
  xdma_pkg::addr_t beat_addr;
  xdma_pkg::addr_t first_base;
  xdma_pkg::len_t  beats_eff;
  xdma_pkg::len_t  left;
  logic            is_last;

  // Output register free or draining this cycle
  assign ready_o = !out_valid_q || out_ready_i;
  assign accept  = valid_i && ready_o;
  assign first_o = first_q;

  always_comb begin
    first_base = xdma_pkg::window_base(desc_i.peer_addr, xdma_pkg::window_e'(Window));
    // Zero length still sends one beat
    beats_eff  = (desc_i.beats == '0) ? xdma_pkg::len_t'(1) : desc_i.beats;
    if (first_q) begin
      beat_addr = first_base;
      left      = beats_eff - xdma_pkg::len_t'(1);
    end else begin
      // Beat i sits i beats above the window base
      beat_addr = base_q + xdma_pkg::addr_t'(beat_cnt_q) * BeatBytes;
      left      = remain_q;
    end
    is_last = (left == '0);
  end

  // ------------------------------
  // Burst control
  // ------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      first_q     <= 1'b1;
      beat_cnt_q  <= '0;
      remain_q    <= '0;
      out_valid_q <= 1'b0;
    end else begin
      if (accept) begin
        first_q     <= is_last;
        beat_cnt_q  <= first_q ? xdma_pkg::len_t'(1) : beat_cnt_q + xdma_pkg::len_t'(1);
        remain_q    <= left - xdma_pkg::len_t'(1);
        out_valid_q <= 1'b1;
      end else if (out_ready_i) begin
        out_valid_q <= 1'b0;
      end
    end
  end

  // Payload side, no reset
  always_ff @(posedge clk_i) begin
    if (accept) begin
      out_q.addr <= beat_addr;
      out_q.data <= data_i;
      out_q.last <= is_last;
      // Base kept for the rest of the burst
      if (first_q) begin
        base_q <= first_base;
      end
    end
  end

  assign out_o       = out_q;
  assign out_valid_o = out_valid_q;

endmodule

// File: xdma_config.svh
`ifndef XDMA_CONFIG_SVH
`define XDMA_CONFIG_SVH

// ------------------------------
// Address layout
// ------------------------------
// Byte address width
`define XDMA_ADDR_W 48
// Chip id sits in the top bits of the address
`define XDMA_CHIP_ID_W 8

// ------------------------------
// Payload and burst sizes
// ------------------------------
`define XDMA_NARROW_W 64
`define XDMA_WIDE_W 512
// Beat count field of a descriptor
`define XDMA_LEN_W 16

// ------------------------------
// Memory map constants
// ------------------------------
// One cluster spans 1 MiB
`define XDMA_CLUSTER_SPACE 48'h10_0000
// Checked against the low 40 bits only
`define XDMA_MAIN_MEM_BASE 40'h00_8000_0000
`define XDMA_MAIN_MEM_END 48'h1_0000_0000
// Each MMIO window below the region end
`define XDMA_WINDOW_BYTES 4096

// Max grants held at once
`define XDMA_GRANT_DEPTH 3

`endif

// File: xdma_grant_gate.sv
`timescale 1ns/10ps

`include "xdma_config.svh"

module xdma_grant_gate (
  input  logic clk_i,
  input  logic rst_ni,
  // Data stream between the source and the data writer
  input  logic data_valid_i,
  input  logic first_i,
  input  logic writer_ready_i,
  output logic data_valid_o,
  output logic data_ready_o,
  // Grant words from the receive side
  input  logic grant_valid_i,
  output logic grant_ready_o
);

  localparam int unsigned CntW = $clog2(`XDMA_GRANT_DEPTH + 1);
  localparam logic [CntW-1:0] MaxCredits = CntW'(`XDMA_GRANT_DEPTH);

  // ------------------------------
  // Credit counter
  // ------------------------------
  logic [CntW-1:0] credit_q;
  logic            has_credit;
  logic            allow;
  logic            consume;
  logic            add;

  assign has_credit = (credit_q != '0);

  // Only the opening beat needs a credit
  // Later beats of the burst go through freely
  assign allow = !first_i || has_credit;

  assign data_valid_o = data_valid_i && allow;
  assign data_ready_o = writer_ready_i && allow;

  // One credit per burst, spent on the first beat transfer
  assign consume = data_valid_i && writer_ready_i && first_i && has_credit;

  // Stop taking grants once full
  assign grant_ready_o = (credit_q != MaxCredits);
  assign add           = grant_valid_i && grant_ready_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      credit_q <= '0;
    end else begin
      case ({add, consume})
        2'b10:   credit_q <= credit_q + CntW'(1);
        2'b01:   credit_q <= credit_q - CntW'(1);
        // Both or neither, count unchanged
        default: credit_q <= credit_q;
      endcase
    end
  end

endmodule

// File: xdma_pkg.sv
`include "xdma_config.svh"

package xdma_pkg;

  // ------------------------------
  // Widths
  // ------------------------------
  localparam int unsigned AddrW = `XDMA_ADDR_W;
  localparam int unsigned ChipIdW = `XDMA_CHIP_ID_W;
  // Part of the address below the chip id
  localparam int unsigned LowW = AddrW - ChipIdW;

  // ------------------------------
  // Basic types
  // ------------------------------
  typedef logic [AddrW-1:0] addr_t;
  typedef logic [`XDMA_LEN_W-1:0] len_t;
  typedef logic [`XDMA_NARROW_W-1:0] narrow_data_t;
  typedef logic [`XDMA_WIDE_W-1:0] wide_data_t;

  // Per-burst side info, sampled with the first beat
  // A beat count of zero counts as one
  typedef struct packed {
    addr_t peer_addr;
    len_t  beats;
  } xfer_desc_t;

  // Outbound / inbound narrow write beat
  typedef struct packed {
    addr_t        addr;
    narrow_data_t data;
    logic         last;
  } narrow_beat_t;

  // Same for the wide side
  typedef struct packed {
    addr_t      addr;
    wide_data_t data;
    logic       last;
  } wide_beat_t;

  // Windows counted down from the region end
  typedef enum logic [1:0] {
    DataWin   = 2'd0,
    CfgWin    = 2'd1,
    GrantWin  = 2'd2,
    FinishWin = 2'd3
  } window_e;

  // ------------------------------
  // Address mapping
  // ------------------------------
  // First byte past the region that holds addr
  function automatic addr_t region_end(addr_t addr);
    addr_t mem_end;
    addr_t cl_mask;
    mem_end = addr_t'(`XDMA_MAIN_MEM_END);
    // Clears the offset inside one cluster
    cl_mask = ~(addr_t'(`XDMA_CLUSTER_SPACE) - addr_t'(1));
    if (addr[LowW-1:0] >= `XDMA_MAIN_MEM_BASE) begin
      // Main memory of the chip named in the top bits
      return {addr[AddrW-1:LowW], mem_end[LowW-1:0]};
    end
    return (addr & cl_mask) + addr_t'(`XDMA_CLUSTER_SPACE);
  endfunction

  // Start of window win below the region end
  function automatic addr_t window_base(addr_t addr, window_e win);
    addr_t offset;
    offset = addr_t'((int'(win) + 1) * `XDMA_WINDOW_BYTES);
    return region_end(addr) - offset;
  endfunction

  // Bytes per beat for a payload width in bits
  function automatic int unsigned beat_bytes(int unsigned width);
    return width / 8;
  endfunction

endpackage

// File: xdma_window_demux.sv
`timescale 1ns/10ps

`include "xdma_config.svh"

module xdma_window_demux (
  // Own cluster base, static
  input  xdma_pkg::addr_t        cluster_base_i,
  // Narrow inbound writes
  input  xdma_pkg::narrow_beat_t in_i,
  input  logic                   in_valid_i,
  output logic                   in_ready_o,
  // Configuration stream
  output xdma_pkg::narrow_data_t cfg_o,
  output logic                   cfg_valid_o,
  input  logic                   cfg_ready_i,
  // Grant stream, content not needed
  output logic                   grant_valid_o,
  input  logic                   grant_ready_i,
  // Finish stream
  output xdma_pkg::narrow_data_t finish_o,
  output logic                   finish_valid_o,
  input  logic                   finish_ready_i
);

  // ------------------------------
  // Local window decode
  // ------------------------------
  xdma_pkg::addr_t cfg_base;
  xdma_pkg::addr_t grant_base;
  xdma_pkg::addr_t finish_base;
  logic            hit_cfg;
  logic            hit_grant;
  logic            hit_finish;

  // Below base wraps to a large offset, so one compare covers both ends
  function automatic logic in_window(xdma_pkg::addr_t addr, xdma_pkg::addr_t base);
    xdma_pkg::addr_t offset;
    offset = addr - base;
    return offset < xdma_pkg::addr_t'(`XDMA_WINDOW_BYTES);
  endfunction

  assign cfg_base    = xdma_pkg::window_base(cluster_base_i, xdma_pkg::CfgWin);
  assign grant_base  = xdma_pkg::window_base(cluster_base_i, xdma_pkg::GrantWin);
  assign finish_base = xdma_pkg::window_base(cluster_base_i, xdma_pkg::FinishWin);

  assign hit_cfg    = in_window(in_i.addr, cfg_base);
  assign hit_grant  = in_window(in_i.addr, grant_base);
  assign hit_finish = in_window(in_i.addr, finish_base);

  // ------------------------------
  // Steering
  // ------------------------------
  // Data fans out, valid goes to one port only
  assign cfg_o          = in_i.data;
  assign finish_o       = in_i.data;
  assign cfg_valid_o    = in_valid_i && hit_cfg;
  assign grant_valid_o  = in_valid_i && hit_grant;
  assign finish_valid_o = in_valid_i && hit_finish;

  // Windows never overlap
  always_comb begin
    if (hit_cfg) begin
      in_ready_o = cfg_ready_i;
    end else if (hit_grant) begin
      in_ready_o = grant_ready_i;
    end else if (hit_finish) begin
      in_ready_o = finish_ready_i;
    end else begin
      // Stray write, taken and dropped
      in_ready_o = 1'b1;
    end
  end

endmodule
